/* rv64_idu.f */
+incdir+.
rv64_idu_pkg.sv
rv64_inst_decoder.sv
rv64_imm_gen.sv
rv64_gpr_file.sv
rv64_idu.sv
tb_clk_gen.sv
tb_idu_checker.sv
tb_rv64_idu.sv

/* tb_rv64_idu.sv */
// one table entry per cycle, expected register data kept in a model updated by the table writes
`timescale 1ns/10ps
`include "rv64_idu_settings.svh"

module tb_rv64_idu;
  import rv64_idu_pkg::*;

  logic clk, arst_n;
  inst_t inst;
  logic wen;
  reg_addr_t waddr;
  xlen_t wdata, rs1_data, rs2_data, imm;
  reg_addr_t rd;
  idu_ctrl_t ctrl;
  logic valid;
  logic [95:0] cur_name;
  idu_ctrl_t exp_ctrl;
  xlen_t exp_imm, exp_rs1, exp_rs2;
  reg_addr_t exp_rd;
  int ctrl_errs, imm_errs, reg_errs, checks;

  logic [95:0] t_name [128];
  inst_t       t_inst [128];
  reg_addr_t   t_rd [128];
  logic        t_wen [128];
  reg_addr_t   t_waddr [128];
  xlen_t       t_wdata [128];
  idu_ctrl_t   t_ctrl [128];
  xlen_t       t_imm [128];
  int n_entries = 0;
  xlen_t model [32];
  int seed = 35863;
  int cycles = 0;
  int limit = 1000;
  logic done = 1'b0;

  tb_clk_gen u_clk (.o_clk(clk), .o_arst_n(arst_n));

  rv64_idu i_dut (
    .i_clk(clk), .i_arst_n(arst_n), .i_inst(inst), .i_ws_rf_wen(wen),
    .i_ws_rf_waddr(waddr), .i_gpr_wdata(wdata), .o_rd(rd), .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data), .o_imm(imm), .o_ctrl(ctrl)
  );

  tb_idu_checker u_checker (
    .i_clk(clk), .i_valid(valid), .i_name(cur_name), .i_ctrl(ctrl), .i_imm(imm),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_rd(rd), .i_exp_ctrl(exp_ctrl),
    .i_exp_imm(exp_imm), .i_exp_rs1(exp_rs1), .i_exp_rs2(exp_rs2), .i_exp_rd(exp_rd),
    .o_ctrl_errs(ctrl_errs), .o_imm_errs(imm_errs), .o_reg_errs(reg_errs), .o_checks(checks)
  );

  // fields in idu_ctrl_t order
  function automatic idu_ctrl_t mk_ctrl(input logic rw, input logic m2r, input logic mw,
      input logic mr, input mem_op_t mo, input logic a, input logic [1:0] b,
      input alu_ctr_t alu, input br_func_t br, input logic wc, input ex_ctr_t ex,
      input logic inv);
    return {rw, m2r, mw, mr, mo, a, b, alu, br, wc, ex, inv};
  endfunction

  function automatic idu_ctrl_t ctrl_r(input alu_ctr_t alu, input logic wc);
    return mk_ctrl(1, 0, 0, 0, `MEM_NONE, 0, 2'b00, alu, `BR_NONE, wc, `EX_NONE, 0);
  endfunction

  function automatic idu_ctrl_t ctrl_i(input alu_ctr_t alu, input logic wc);
    return mk_ctrl(1, 0, 0, 0, `MEM_NONE, 0, 2'b01, alu, `BR_NONE, wc, `EX_NONE, 0);
  endfunction

  function automatic idu_ctrl_t ctrl_idle(input logic inv);
    return mk_ctrl(0, 0, 0, 0, `MEM_NONE, 0, 2'b00, `ALU_INVALID, `BR_NONE, 0, `EX_NONE, inv);
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] im, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {im, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] im, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {im[11:5], rs2, rs1, f3, im[4:0], `OPC_STORE};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] im, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], `OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] im, input logic [4:0] rd);
    return {im[20], im[10:1], im[11], im[19:12], rd, `OPC_JAL};
  endfunction

  task automatic add_entry(input logic [95:0] name, input inst_t in, input reg_addr_t rdx,
      input logic we, input reg_addr_t wa, input xlen_t wd, input idu_ctrl_t c,
      input xlen_t im);
    t_name[n_entries]  = name;
    t_inst[n_entries]  = in;
    t_rd[n_entries]    = rdx;
    t_wen[n_entries]   = we;
    t_waddr[n_entries] = wa;
    t_wdata[n_entries] = wd;
    t_ctrl[n_entries]  = c;
    t_imm[n_entries]   = im;
    n_entries++;
  endtask

  task automatic add_plain(input logic [95:0] name, input inst_t in, input reg_addr_t rdx,
      input idu_ctrl_t c, input xlen_t im);
    add_entry(name, in, rdx, 0, 0, 0, c, im);
  endtask

  function automatic xlen_t rand_word();
    xlen_t w;
    w = {$random(seed), $random(seed)};
    return w;
  endfunction

  // rd column is bits 11:7 of the word, imm bits for stores and branches
  task automatic build_table();
    for (int k = 0; k < 16; k++)  // every register reads zero after reset
      add_plain("rst_read", enc_r(0, 2*k+1, 2*k, 0, 1, `OPC_OP), 1, ctrl_r(`ALU_ADD, 0), 0);
    add_entry("wr_x5", 0, 0, 1, 5, rand_word(), ctrl_idle(0), 0);
    add_entry("wr_x6", 0, 0, 1, 6, rand_word(), ctrl_idle(0), 0);
    add_entry("wr_x7", 0, 0, 1, 7, rand_word(), ctrl_idle(0), 0);
    add_plain("add", enc_r(0, 6, 5, 0, 1, `OPC_OP), 1, ctrl_r(`ALU_ADD, 0), 0);
    add_entry("wr_x0", 0, 0, 1, 0, rand_word(), ctrl_idle(0), 0);
    add_plain("sub", enc_r(7'h20, 7, 0, 0, 2, `OPC_OP), 2, ctrl_r(`ALU_SUB, 0), 0);
    add_entry("wr_same_cyc", enc_r(0, 9, 8, 0, 3, `OPC_OP), 3, 1, 8, rand_word(),
              ctrl_r(`ALU_ADD, 0), 0);  // old value still read
    add_plain("rd_after", enc_r(0, 9, 8, 0, 3, `OPC_OP), 3, ctrl_r(`ALU_ADD, 0), 0);
    add_plain("addi", enc_i(12'hffb, 5, 0, 1, `OPC_OP_IMM), 1, ctrl_i(`ALU_ADD, 0),
              -64'sd5);
    add_plain("slti", enc_i(100, 6, 2, 1, `OPC_OP_IMM), 1, ctrl_i(`ALU_SLT, 0), 100);
    add_plain("lui", {20'h80001, 5'd1, `OPC_LUI}, 1, ctrl_i(`ALU_COPY_IMM, 0),
              64'hffff_ffff_8000_1000);
    add_plain("auipc", {20'h12345, 5'd1, `OPC_AUIPC}, 1,
              mk_ctrl(1, 0, 0, 0, `MEM_NONE, 1, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0),
              64'h1234_5000);
    add_plain("jal", enc_j(21'h1ffff8, 1), 1,
              mk_ctrl(1, 0, 0, 0, `MEM_NONE, 1, 2'b10, `ALU_ADD, `BR_JAL, 0, `EX_NONE, 0),
              -64'sd8);
    add_plain("jalr", enc_i(16, 5, 0, 1, `OPC_JALR), 1,
              mk_ctrl(1, 0, 0, 0, `MEM_NONE, 1, 2'b10, `ALU_ADD, `BR_JALR, 0, `EX_NONE, 0), 16);
    add_plain("beq", enc_b(13'h0aaa, 6, 5, 0), 11,
              mk_ctrl(0, 0, 0, 0, `MEM_NONE, 0, 2'b00, `ALU_SLT, `BR_BEQ, 0, `EX_NONE, 0),
              64'h0aaa);
    add_plain("bgeu", enc_b(13'h1ffe, 6, 5, 7), 31,
              mk_ctrl(0, 0, 0, 0, `MEM_NONE, 0, 2'b00, `ALU_SLTU, `BR_BGE, 0, `EX_NONE, 0),
              -64'sd2);
    add_plain("lb", enc_i(12'hfff, 5, 0, 1, `OPC_LOAD), 1,
              mk_ctrl(1, 1, 0, 1, `MEM_LB, 0, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0),
              -64'sd1);
    add_plain("lhu", enc_i(8, 5, 5, 1, `OPC_LOAD), 1,
              mk_ctrl(1, 1, 0, 1, `MEM_LHU, 0, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0), 8);
    add_plain("ld", enc_i(0, 5, 3, 1, `OPC_LOAD), 1,
              mk_ctrl(1, 1, 0, 1, `MEM_LD, 0, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0), 0);
    add_plain("sw", enc_s(12'h7f3, 6, 5, 2), 19,
              mk_ctrl(0, 0, 1, 0, `MEM_LW, 0, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0),
              64'h7f3);
    add_plain("sd", enc_s(12'hff0, 7, 5, 3), 16,
              mk_ctrl(0, 0, 1, 0, `MEM_LD, 0, 2'b01, `ALU_ADD, `BR_NONE, 0, `EX_NONE, 0),
              -64'sd16);
    add_plain("sll", enc_r(0, 6, 5, 1, 1, `OPC_OP), 1, ctrl_r(`ALU_SLL, 0), 0);
    add_plain("srl", enc_r(0, 6, 5, 5, 1, `OPC_OP), 1, ctrl_r(`ALU_SRL, 0), 0);
    add_plain("sra", enc_r(7'h20, 6, 5, 5, 1, `OPC_OP), 1, ctrl_r(`ALU_SRA, 0), 0);
    add_plain("slli", enc_i(33, 5, 1, 1, `OPC_OP_IMM), 1, ctrl_i(`ALU_SLL, 0), 33);
    add_plain("srli", enc_i(33, 5, 5, 1, `OPC_OP_IMM), 1, ctrl_i(`ALU_SRL, 0), 33);
    add_plain("srai", enc_i(12'h421, 5, 5, 1, `OPC_OP_IMM), 1, ctrl_i(`ALU_SRA, 0),
              64'h421);
    add_plain("addw", enc_r(0, 6, 5, 0, 1, `OPC_OP_32), 1, ctrl_r(`ALU_ADD, 1), 0);
    add_plain("subw", enc_r(7'h20, 6, 5, 0, 1, `OPC_OP_32), 1, ctrl_r(`ALU_SUB, 1), 0);
    add_plain("addiw", enc_i(7, 5, 0, 1, `OPC_OP_IMM_32), 1, ctrl_i(`ALU_ADD, 1), 7);
    add_plain("slliw", enc_i(3, 5, 1, 1, `OPC_OP_IMM_32), 1, ctrl_i(`ALU_SLL, 1), 3);
    add_plain("srliw", enc_i(3, 5, 5, 1, `OPC_OP_IMM_32), 1, ctrl_i(`ALU_SRL, 1), 3);
    add_plain("sraiw", enc_i(12'h403, 5, 5, 1, `OPC_OP_IMM_32), 1, ctrl_i(`ALU_SRA, 1),
              64'h403);
    add_plain("sllw", enc_r(0, 6, 5, 1, 1, `OPC_OP_32), 1, ctrl_r(`ALU_SLL, 1), 0);
    add_plain("srlw", enc_r(0, 6, 5, 5, 1, `OPC_OP_32), 1, ctrl_r(`ALU_SRL, 1), 0);
    add_plain("sraw", enc_r(7'h20, 6, 5, 5, 1, `OPC_OP_32), 1, ctrl_r(`ALU_SRA, 1), 0);
    add_plain("unknown", 32'h0000_007f, 0, ctrl_idle(1), 0);
    add_plain("mul", enc_r(7'h01, 6, 5, 0, 1, `OPC_OP), 1, ctrl_idle(1), 0);
    add_plain("ebreak", 32'h0010_0073, 0,
              mk_ctrl(0, 0, 0, 0, `MEM_NONE, 0, 2'b01, `ALU_INVALID, `BR_NONE, 0,
                      `EX_EBREAK, 0), 1);  // I format, imm field holds 1
    add_plain("zero", 0, 0, ctrl_idle(0), 0);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit && !done) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    inst     = '0;
    wen      = 1'b0;
    waddr    = '0;
    wdata    = '0;
    valid    = 1'b0;
    cur_name = '0;
    exp_ctrl = '0;
    exp_imm  = '0;
    exp_rs1  = '0;
    exp_rs2  = '0;
    exp_rd   = '0;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    build_table();
    limit = 5 + n_entries + 20;
    @(posedge arst_n);
    for (int i = 0; i < n_entries; i++) begin
      @(negedge clk);
      inst     = t_inst[i];
      wen      = t_wen[i];
      waddr    = t_waddr[i];
      wdata    = t_wdata[i];
      cur_name = t_name[i];
      exp_ctrl = t_ctrl[i];
      exp_imm  = t_imm[i];
      exp_rd   = t_rd[i];
      exp_rs1  = model[t_inst[i][19:15]];
      exp_rs2  = model[t_inst[i][24:20]];
      valid    = 1'b1;
      if (t_wen[i] && t_waddr[i] != 0) model[t_waddr[i]] = t_wdata[i];  // lands on next edge
    end
    @(negedge clk);
    valid = 1'b0;
    wen   = 1'b0;
    done  = 1'b1;
    $display("error counts: ctrl %0d imm %0d reg %0d over %0d checks", ctrl_errs, imm_errs,
             reg_errs, checks);
    if (ctrl_errs + imm_errs + reg_errs == 0 && checks == n_entries) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tb_idu_checker.sv */
// samples the DUT on the rising edge, before a write on that edge reaches the read ports
`timescale 1ns/10ps

module tb_idu_checker (
  input  logic                    i_clk,
  input  logic                    i_valid,
  input  logic [95:0]             i_name,
  input  rv64_idu_pkg::idu_ctrl_t i_ctrl,
  input  rv64_idu_pkg::xlen_t     i_imm,
  input  rv64_idu_pkg::xlen_t     i_rs1_data,
  input  rv64_idu_pkg::xlen_t     i_rs2_data,
  input  rv64_idu_pkg::reg_addr_t i_rd,
  input  rv64_idu_pkg::idu_ctrl_t i_exp_ctrl,
  input  rv64_idu_pkg::xlen_t     i_exp_imm,
  input  rv64_idu_pkg::xlen_t     i_exp_rs1,
  input  rv64_idu_pkg::xlen_t     i_exp_rs2,
  input  rv64_idu_pkg::reg_addr_t i_exp_rd,
  output int                      o_ctrl_errs,
  output int                      o_imm_errs,
  output int                      o_reg_errs,
  output int                      o_checks
);

  initial begin
    o_ctrl_errs = 0;
    o_imm_errs  = 0;
    o_reg_errs  = 0;
    o_checks    = 0;
  end

  always @(posedge i_clk) begin
    if (i_valid) begin
      o_checks = o_checks + 1;
      if (i_ctrl !== i_exp_ctrl) begin
        $display("** Error %0s: ctrl expected %h actual %h", i_name, i_exp_ctrl, i_ctrl);
        o_ctrl_errs = o_ctrl_errs + 1;
      end
      if (i_rd !== i_exp_rd) begin
        $display("** Error %0s: rd expected %0d actual %0d", i_name, i_exp_rd, i_rd);
        o_ctrl_errs = o_ctrl_errs + 1;
      end
      if (i_imm !== i_exp_imm) begin
        $display("** Error %0s: imm expected %h actual %h", i_name, i_exp_imm, i_imm);
        o_imm_errs = o_imm_errs + 1;
      end
      if (i_rs1_data !== i_exp_rs1) begin
        $display("** Error %0s: rs1 data expected %h actual %h", i_name, i_exp_rs1,
                 i_rs1_data);
        o_reg_errs = o_reg_errs + 1;
      end
      if (i_rs2_data !== i_exp_rs2) begin
        $display("** Error %0s: rs2 data expected %h actual %h", i_name, i_exp_rs2,
                 i_rs2_data);
        o_reg_errs = o_reg_errs + 1;
      end
    end
  end

endmodule

/* tb_clk_gen.sv */
// free running 20 ns clock, reset held low for 5 cycles and released on a falling edge
`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);
  initial begin
    o_clk    = 1'b0;
    o_arst_n = 1'b0;
    repeat (5) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

  always #10 o_clk = ~o_clk;  // 20 ns period

endmodule

/* rv64_idu.sv */
// decode and immediate are combinational and register reads see writes from earlier clock edges only
`timescale 1ns/10ps

module rv64_idu (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  rv64_idu_pkg::inst_t     i_inst,
  input  logic                    i_ws_rf_wen,
  input  rv64_idu_pkg::reg_addr_t i_ws_rf_waddr,
  input  rv64_idu_pkg::xlen_t     i_gpr_wdata,
  output rv64_idu_pkg::reg_addr_t o_rd,
  output rv64_idu_pkg::xlen_t     o_rs1_data,
  output rv64_idu_pkg::xlen_t     o_rs2_data,
  output rv64_idu_pkg::xlen_t     o_imm,
  output rv64_idu_pkg::idu_ctrl_t o_ctrl
);
  import rv64_idu_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  imm_fmt_t  imm_fmt;

  assign o_rd     = i_inst[11:7];
  assign rs1_addr = i_inst[19:15];
  assign rs2_addr = i_inst[24:20];

  rv64_inst_decoder u_decoder (
    .i_inst    (i_inst),
    .o_ctrl    (o_ctrl),
    .o_imm_fmt (imm_fmt)
  );

  rv64_imm_gen u_imm_gen (
    .i_inst    (i_inst),
    .i_imm_fmt (imm_fmt),
    .o_imm     (o_imm)
  );

  // write port follows writeback, not the decoded rd
  rv64_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1_addr),
    .i_raddr2 (rs2_addr),
    .i_waddr  (i_ws_rf_waddr),
    .i_wdata  (i_gpr_wdata),
    .i_wen    (i_ws_rf_wen),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

/* rv64_gpr_file.sv */
// x0 reads as zero and reads are combinational with no bypass of a write in the same cycle
`timescale 1ns/10ps
`include "rv64_idu_settings.svh"

module rv64_gpr_file (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  rv64_idu_pkg::reg_addr_t i_raddr1,
  input  rv64_idu_pkg::reg_addr_t i_raddr2,
  input  rv64_idu_pkg::reg_addr_t i_waddr,
  input  rv64_idu_pkg::xlen_t     i_wdata,
  input  logic                    i_wen,
  output rv64_idu_pkg::xlen_t     o_rdata1,
  output rv64_idu_pkg::xlen_t     o_rdata2
);
  import rv64_idu_pkg::*;

  xlen_t gpr_q [`NUM_GPR];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin  // x0 writes dropped
      gpr_q[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr_q[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr_q[i_raddr2];

endmodule

/* rv64_imm_gen.sv */
// every format sign-extends from inst[31] and the none format gives a zero immediate
`timescale 1ns/10ps
`include "rv64_idu_settings.svh"

module rv64_imm_gen (
  input  rv64_idu_pkg::inst_t    i_inst,
  input  rv64_idu_pkg::imm_fmt_t i_imm_fmt,
  output rv64_idu_pkg::xlen_t    o_imm
);
  import rv64_idu_pkg::*;

  xlen_t imm_i;
  xlen_t imm_u;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_j;

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  // bit 12 comes from the sign fill
  assign imm_b = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(`XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_imm_fmt)
      `IMM_I:    o_imm = imm_i;
      `IMM_U:    o_imm = imm_u;
      `IMM_S:    o_imm = imm_s;
      `IMM_B:    o_imm = imm_b;
      `IMM_J:    o_imm = imm_j;
      `IMM_NONE: o_imm = '0;  // R type
      default:   o_imm = '0;
    endcase
  end

endmodule

/* rv64_inst_decoder.sv */
// pure RV64I decode where M, Zicsr, ecall, mret and fence all fall through as invalid
`timescale 1ns/10ps
`include "rv64_idu_settings.svh"

module rv64_inst_decoder (
  input  rv64_idu_pkg::inst_t     i_inst,
  output rv64_idu_pkg::idu_ctrl_t o_ctrl,
  output rv64_idu_pkg::imm_fmt_t  o_imm_fmt
);
  import rv64_idu_pkg::*;

  wire [6:0] opcode = i_inst[6:0];
  wire [2:0] funct3 = i_inst[14:12];
  wire [6:0] funct7 = i_inst[31:25];

  wire f7_base  = (funct7 == 7'b0000000);
  wire f7_alt   = (funct7 == 7'b0100000);
  wire sh6_base = (funct7[6:1] == 6'b000000);  // 64-bit shamt uses bit 25
  wire sh6_alt  = (funct7[6:1] == 6'b010000);

  wire op_lui    = (opcode == `OPC_LUI);
  wire op_auipc  = (opcode == `OPC_AUIPC);
  wire op_jal    = (opcode == `OPC_JAL);
  wire op_jalr   = (opcode == `OPC_JALR);
  wire op_branch = (opcode == `OPC_BRANCH);
  wire op_load   = (opcode == `OPC_LOAD);
  wire op_store  = (opcode == `OPC_STORE);
  wire op_imm    = (opcode == `OPC_OP_IMM);
  wire op_reg    = (opcode == `OPC_OP);
  wire op_imm32  = (opcode == `OPC_OP_IMM_32);
  wire op_reg32  = (opcode == `OPC_OP_32);
  wire op_system = (opcode == `OPC_SYSTEM);

  wire inst_jalr   = op_jalr & (funct3 == 3'b000);
  wire inst_beq    = op_branch & (funct3 == 3'b000);
  wire inst_bne    = op_branch & (funct3 == 3'b001);
  wire inst_blt    = op_branch & (funct3 == 3'b100);
  wire inst_bge    = op_branch & (funct3 == 3'b101);
  wire inst_bltu   = op_branch & (funct3 == 3'b110);
  wire inst_bgeu   = op_branch & (funct3 == 3'b111);
  wire inst_lb     = op_load & (funct3 == 3'b000);
  wire inst_lh     = op_load & (funct3 == 3'b001);
  wire inst_lw     = op_load & (funct3 == 3'b010);
  wire inst_ld     = op_load & (funct3 == 3'b011);
  wire inst_lbu    = op_load & (funct3 == 3'b100);
  wire inst_lhu    = op_load & (funct3 == 3'b101);
  wire inst_lwu    = op_load & (funct3 == 3'b110);
  wire inst_sb     = op_store & (funct3 == 3'b000);
  wire inst_sh     = op_store & (funct3 == 3'b001);
  wire inst_sw     = op_store & (funct3 == 3'b010);
  wire inst_sd     = op_store & (funct3 == 3'b011);
  wire inst_addi   = op_imm & (funct3 == 3'b000);
  wire inst_slti   = op_imm & (funct3 == 3'b010);
  wire inst_sltiu  = op_imm & (funct3 == 3'b011);
  wire inst_xori   = op_imm & (funct3 == 3'b100);
  wire inst_ori    = op_imm & (funct3 == 3'b110);
  wire inst_andi   = op_imm & (funct3 == 3'b111);
  wire inst_slli   = op_imm & (funct3 == 3'b001) & sh6_base;
  wire inst_srli   = op_imm & (funct3 == 3'b101) & sh6_base;
  wire inst_srai   = op_imm & (funct3 == 3'b101) & sh6_alt;
  wire inst_add    = op_reg & (funct3 == 3'b000) & f7_base;
  wire inst_sub    = op_reg & (funct3 == 3'b000) & f7_alt;
  wire inst_sll    = op_reg & (funct3 == 3'b001) & f7_base;
  wire inst_slt    = op_reg & (funct3 == 3'b010) & f7_base;
  wire inst_sltu   = op_reg & (funct3 == 3'b011) & f7_base;
  wire inst_xor    = op_reg & (funct3 == 3'b100) & f7_base;
  wire inst_srl    = op_reg & (funct3 == 3'b101) & f7_base;
  wire inst_sra    = op_reg & (funct3 == 3'b101) & f7_alt;
  wire inst_or     = op_reg & (funct3 == 3'b110) & f7_base;
  wire inst_and    = op_reg & (funct3 == 3'b111) & f7_base;
  wire inst_addiw  = op_imm32 & (funct3 == 3'b000);
  wire inst_slliw  = op_imm32 & (funct3 == 3'b001) & f7_base;
  wire inst_srliw  = op_imm32 & (funct3 == 3'b101) & f7_base;
  wire inst_sraiw  = op_imm32 & (funct3 == 3'b101) & f7_alt;
  wire inst_addw   = op_reg32 & (funct3 == 3'b000) & f7_base;
  wire inst_subw   = op_reg32 & (funct3 == 3'b000) & f7_alt;
  wire inst_sllw   = op_reg32 & (funct3 == 3'b001) & f7_base;
  wire inst_srlw   = op_reg32 & (funct3 == 3'b101) & f7_base;
  wire inst_sraw   = op_reg32 & (funct3 == 3'b101) & f7_alt;
  wire inst_ebreak = op_system & (i_inst == `INST_EBREAK);

  wire inst_load  = |{inst_lb, inst_lh, inst_lw, inst_ld, inst_lbu, inst_lhu, inst_lwu};
  wire inst_store = |{inst_sb, inst_sh, inst_sw, inst_sd};
  wire inst_word  = |{inst_addiw, inst_slliw, inst_srliw, inst_sraiw,
                      inst_addw, inst_subw, inst_sllw, inst_srlw, inst_sraw};

  wire type_r = |{inst_add, inst_sub, inst_sll, inst_slt, inst_sltu, inst_xor, inst_srl,
                  inst_sra, inst_or, inst_and, inst_addw, inst_subw, inst_sllw, inst_srlw,
                  inst_sraw};
  wire type_i = |{inst_jalr, inst_load, inst_addi, inst_slti, inst_sltiu, inst_xori,
                  inst_ori, inst_andi, inst_slli, inst_srli, inst_srai, inst_addiw,
                  inst_slliw, inst_srliw, inst_sraiw, inst_ebreak};
  wire type_u = op_lui | op_auipc;
  wire type_s = inst_store;
  wire type_b = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  wire type_j = op_jal;

  // alu operation groups, at most one is set
  wire alu_copy = op_lui;
  wire alu_add  = |{op_auipc, op_jal, inst_jalr, inst_addi, inst_add, inst_load, inst_store,
                    inst_addiw, inst_addw};
  wire alu_sub  = inst_sub | inst_subw;
  wire alu_slt  = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_slt, inst_slti};
  wire alu_sltu = |{inst_bltu, inst_bgeu, inst_sltu, inst_sltiu};
  wire alu_xor  = inst_xor | inst_xori;
  wire alu_and  = inst_and | inst_andi;
  wire alu_or   = inst_or | inst_ori;
  wire alu_sll  = |{inst_sll, inst_slli, inst_slliw, inst_sllw};
  wire alu_srl  = |{inst_srl, inst_srli, inst_srliw, inst_srlw};
  wire alu_sra  = |{inst_sra, inst_srai, inst_sraiw, inst_sraw};

  alu_ctr_t alu_ctr;
  mem_op_t  mem_op;
  br_func_t br_func;
  ex_ctr_t  ex_ctr;

  always_comb begin
    case ({type_i, type_u, type_s, type_b, type_j})
      5'b10000: o_imm_fmt = `IMM_I;
      5'b01000: o_imm_fmt = `IMM_U;
      5'b00100: o_imm_fmt = `IMM_S;
      5'b00010: o_imm_fmt = `IMM_B;
      5'b00001: o_imm_fmt = `IMM_J;
      default:  o_imm_fmt = `IMM_NONE;  // R type and unknown
    endcase
  end

  always_comb begin
    case ({alu_copy, alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_and, alu_or,
           alu_sll, alu_srl, alu_sra})
      11'b100_0000_0000: alu_ctr = `ALU_COPY_IMM;
      11'b010_0000_0000: alu_ctr = `ALU_ADD;
      11'b001_0000_0000: alu_ctr = `ALU_SUB;
      11'b000_1000_0000: alu_ctr = `ALU_SLT;
      11'b000_0100_0000: alu_ctr = `ALU_SLTU;
      11'b000_0010_0000: alu_ctr = `ALU_XOR;
      11'b000_0001_0000: alu_ctr = `ALU_AND;
      11'b000_0000_1000: alu_ctr = `ALU_OR;
      11'b000_0000_0100: alu_ctr = `ALU_SLL;
      11'b000_0000_0010: alu_ctr = `ALU_SRL;
      11'b000_0000_0001: alu_ctr = `ALU_SRA;
      default:           alu_ctr = `ALU_INVALID;
    endcase
  end

  always_comb begin
    case ({inst_lb | inst_sb, inst_lbu, inst_lh | inst_sh, inst_lhu, inst_lw | inst_sw,
           inst_lwu, inst_ld | inst_sd})
      7'b100_0000: mem_op = `MEM_LB;
      7'b010_0000: mem_op = `MEM_LBU;
      7'b001_0000: mem_op = `MEM_LH;
      7'b000_1000: mem_op = `MEM_LHU;
      7'b000_0100: mem_op = `MEM_LW;
      7'b000_0010: mem_op = `MEM_LWU;
      7'b000_0001: mem_op = `MEM_LD;
      default:     mem_op = `MEM_NONE;
    endcase
  end

  always_comb begin
    case ({op_jal, inst_jalr, inst_beq, inst_bne, inst_blt | inst_bltu, inst_bge | inst_bgeu})
      6'b10_0000: br_func = `BR_JAL;
      6'b01_0000: br_func = `BR_JALR;
      6'b00_1000: br_func = `BR_BEQ;
      6'b00_0100: br_func = `BR_BNE;
      6'b00_0010: br_func = `BR_BLT;
      6'b00_0001: br_func = `BR_BGE;
      default:    br_func = `BR_NONE;
    endcase
  end

  always_comb begin
    case ({alu_ctr == `ALU_INVALID, inst_ebreak})
      2'b11:   ex_ctr = `EX_EBREAK;
      default: ex_ctr = `EX_NONE;
    endcase
  end

  always_comb begin
    o_ctrl.reg_wr     = (type_r | type_i | type_u | type_j) & ~inst_ebreak;
    o_ctrl.mem_to_reg = inst_load;
    o_ctrl.mem_wr     = type_s;
    o_ctrl.mem_re     = inst_load;
    o_ctrl.mem_op     = mem_op;
    o_ctrl.alu_a_src  = op_jal | inst_jalr | op_auipc;  // pc based
    o_ctrl.alu_b_src  = {op_jal | inst_jalr, (type_i | type_u | type_s) & ~inst_jalr};
    o_ctrl.alu_ctr    = alu_ctr;
    o_ctrl.br_func    = br_func;
    o_ctrl.word_cut   = inst_word;
    o_ctrl.ex_ctr     = ex_ctr;
    // all-zero word is a pipeline bubble, not a fault
    o_ctrl.invalid    = (alu_ctr == `ALU_INVALID) && (ex_ctr == `EX_NONE) && (i_inst != '0);
  end

endmodule

/* rv64_idu_pkg.sv */
// field order of idu_ctrl_t is shared with the execute and memory stages and must move with them
`include "rv64_idu_settings.svh"

package rv64_idu_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`ALU_CTR_W-1:0]  alu_ctr_t;
  typedef logic [`MEM_OP_W-1:0]   mem_op_t;
  typedef logic [`BR_FUNC_W-1:0]  br_func_t;
  typedef logic [`EX_CTR_W-1:0]   ex_ctr_t;
  typedef logic [`IMM_FMT_W-1:0]  imm_fmt_t;

  // control bundle handed to the later stages
  typedef struct packed {
    logic       reg_wr;      // write rd at writeback
    logic       mem_to_reg;  // rd takes load data
    logic       mem_wr;
    logic       mem_re;
    mem_op_t    mem_op;      // access size and sign
    logic       alu_a_src;   // 0 rs1, 1 pc
    logic [1:0] alu_b_src;   // 00 rs2, 01 imm, 10 const 4
    alu_ctr_t   alu_ctr;
    br_func_t   br_func;
    logic       word_cut;    // 32-bit op, sign-extend result
    ex_ctr_t    ex_ctr;
    logic       invalid;
  } idu_ctrl_t;

endpackage

/* rv64_idu_settings.svh */
// holds RV64I encodings only and leaves out the M, Zicsr and compressed opcodes
`ifndef RV64_IDU_SETTINGS_SVH
`define RV64_IDU_SETTINGS_SVH

`define XLEN          64
`define INST_W        32
`define REG_ADDR_W    5
`define NUM_GPR       32
`define ALU_CTR_W     5
`define MEM_OP_W      3
`define BR_FUNC_W     3
`define EX_CTR_W      4
`define IMM_FMT_W     3

// major opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011
`define OPC_SYSTEM    7'b1110011
`define INST_EBREAK   32'h00100073

`define ALU_COPY_IMM  5'b01111
`define ALU_ADD       5'b00000
`define ALU_SUB       5'b00001
`define ALU_SLT       5'b00010  // also signed branch compare
`define ALU_SLTU      5'b00011  // also unsigned branch compare
`define ALU_XOR       5'b00100
`define ALU_AND       5'b00101
`define ALU_OR        5'b00110
`define ALU_SLL       5'b00111
`define ALU_SRL       5'b01000
`define ALU_SRA       5'b01001
`define ALU_INVALID   5'b11111

`define MEM_LB        3'b000  // sb shares it
`define MEM_LBU       3'b001
`define MEM_LH        3'b010  // sh shares it
`define MEM_LHU       3'b011
`define MEM_LW        3'b100  // sw shares it
`define MEM_LWU       3'b101
`define MEM_LD        3'b110  // sd shares it
`define MEM_NONE      3'b111

`define BR_NONE       3'b000
`define BR_JAL        3'b001
`define BR_JALR       3'b010
`define BR_BEQ        3'b100
`define BR_BNE        3'b101
`define BR_BLT        3'b110  // bltu too, alu code tells them apart
`define BR_BGE        3'b111  // bgeu too

`define EX_EBREAK     4'b1110
`define EX_NONE       4'b1111

`define IMM_I         3'b000
`define IMM_U         3'b001
`define IMM_S         3'b010
`define IMM_B         3'b011
`define IMM_J         3'b100
`define IMM_NONE      3'b111

`endif
